//--- aluUnit.sv
// RV32I ALU; branch compare runs on its own operand pair, shifts use srcB[4:0]
`timescale 1ns/100ps
`default_nettype none

module aluUnit
    import isaPkg::*;
(
    input  logic [3:0]      aluOp,
    input  logic [xlen-1:0] srcA,
    input  logic [xlen-1:0] srcB,
    input  logic [xlen-1:0] cmpA,
    input  logic [xlen-1:0] cmpB,
    input  logic [2:0]      funct3,
    output logic [xlen-1:0] result,
    output logic            branchTaken
);

    logic [4:0] shamt;

    assign shamt = srcB[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:   result = srcA + srcB;
            aluSub:   result = srcA - srcB;
            aluSll:   result = srcA << shamt;
            aluSlt:   result = {{(xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            aluSltu:  result = {{(xlen-1){1'b0}}, srcA < srcB};
            aluXor:   result = srcA ^ srcB;
            aluSrl:   result = srcA >> shamt;
            aluSra:   result = $signed(srcA) >>> shamt;
            aluOr:    result = srcA | srcB;
            aluAnd:   result = srcA & srcB;
            aluPassB: result = srcB;
            default:  result = '0;
        endcase
    end

    // branch condition from A and B registers
    always_comb begin
        case (funct3)
            f3Beq:   branchTaken = (cmpA == cmpB);
            f3Bne:   branchTaken = (cmpA != cmpB);
            f3Blt:   branchTaken = ($signed(cmpA) < $signed(cmpB));
            f3Bge:   branchTaken = ($signed(cmpA) >= $signed(cmpB));
            f3Bltu:  branchTaken = (cmpA < cmpB);
            f3Bgeu:  branchTaken = (cmpA >= cmpB);
            default: branchTaken = 1'b0; // 010/011 are not branches
        endcase
    end

endmodule

`default_nettype wire

//--- compile.f
isaPkg.sv
ctrlPkg.sv
multiCycleControl.sv
aluUnit.sv
regFile.sv
unifiedMemory.sv
rvMultiCycleTop.sv
tbRvMultiCycle.sv

//--- ctrlPkg.sv
// control encodings for the multicycle sequencer; codes are private to this core
`default_nettype none

package ctrlPkg;

    typedef enum logic [2:0] {
        fetch     = 3'd0,
        decode    = 3'd1,
        execute   = 3'd2,
        memAccess = 3'd3,
        writeBack = 3'd4,
        halt      = 3'd5
    } ctrlState;

    // memory address source
    localparam logic addrPc     = 1'b0;
    localparam logic addrAluOut = 1'b1;

    // alu operand A
    localparam logic [1:0] aSelPc    = 2'd0;
    localparam logic [1:0] aSelOldPc = 2'd1;
    localparam logic [1:0] aSelRegA  = 2'd2;

    // alu operand B
    localparam logic [1:0] bSelRegB = 2'd0;
    localparam logic [1:0] bSelImm  = 2'd1;
    localparam logic [1:0] bSelFour = 2'd2;

    // register writeback source
    localparam logic [1:0] wbAluOut = 2'd0;
    localparam logic [1:0] wbMdr    = 2'd1;
    localparam logic [1:0] wbPc     = 2'd2; // link value, PC already +4

endpackage

`default_nettype wire

//--- isaPkg.sv
// RV32I encodings for this core only; word loads/stores, no CSR, FENCE or compressed forms
`default_nettype none

package isaPkg;

    localparam int xlen        = 32;
    localparam int memWords    = 1024;
    localparam int memAddrBits = 10; // word address, byte address bits [11:2]

    // major opcodes
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opSystem = 7'b1110011; // ECALL halts

    // alu funct3
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101; // funct7 bit 5 picks sra
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // branch funct3
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // internal alu operation codes
    localparam logic [3:0] aluAdd   = 4'd0;
    localparam logic [3:0] aluSub   = 4'd1;
    localparam logic [3:0] aluSll   = 4'd2;
    localparam logic [3:0] aluSlt   = 4'd3;
    localparam logic [3:0] aluSltu  = 4'd4;
    localparam logic [3:0] aluXor   = 4'd5;
    localparam logic [3:0] aluSrl   = 4'd6;
    localparam logic [3:0] aluSra   = 4'd7;
    localparam logic [3:0] aluOr    = 4'd8;
    localparam logic [3:0] aluAnd   = 4'd9;
    localparam logic [3:0] aluPassB = 4'd10; // LUI

endpackage

`default_nettype wire

//--- multiCycleControl.sv
// multicycle FSM; outputs decode from state and IR opcode, memory read data lands one cycle late
`timescale 1ns/100ps
`default_nettype none

module multiCycleControl
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic       branchTaken,
    output logic       pcWrite,
    output logic       pcWriteCond,
    output logic       irWrite,
    output logic       memRead,
    output logic       memWrite,
    output logic       regWrite,
    output logic       addrSel,
    output logic [1:0] aluASel,
    output logic [1:0] aluBSel,
    output logic [1:0] wbSel,
    output logic [3:0] aluOp,
    output logic       halted
);

    ctrlState   state;
    ctrlState   nextState;
    logic [3:0] fieldOp;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= fetch;
        end else begin
            state <= nextState;
        end
    end

    // alu op from funct fields, sub only exists for R-type
    always_comb begin
        case (funct3)
            f3AddSub: fieldOp = (opcode == opR && funct7b5) ? aluSub : aluAdd;
            f3Sll:    fieldOp = aluSll;
            f3Slt:    fieldOp = aluSlt;
            f3Sltu:   fieldOp = aluSltu;
            f3Xor:    fieldOp = aluXor;
            f3SrlSra: fieldOp = funct7b5 ? aluSra : aluSrl;
            f3Or:     fieldOp = aluOr;
            default:  fieldOp = aluAnd;
        endcase
    end

    always_comb begin
        pcWrite     = 1'b0;
        pcWriteCond = 1'b0;
        irWrite     = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        regWrite    = 1'b0;
        addrSel     = addrPc;
        aluASel     = aSelRegA;
        aluBSel     = bSelImm;
        wbSel       = wbAluOut;
        aluOp       = aluAdd;
        nextState   = state;
        case (state)
            fetch: begin
                memRead   = 1'b1; // instruction word arrives in decode
                aluASel   = aSelPc;
                aluBSel   = bSelFour;
                pcWrite   = 1'b1;
                nextState = decode;
            end
            decode: begin
                irWrite   = 1'b1;
                aluASel   = aSelOldPc; // branch or JAL target into ALUOut
                nextState = execute;
            end
            execute: begin
                case (opcode)
                    opR: begin
                        aluBSel   = bSelRegB;
                        aluOp     = fieldOp;
                        nextState = writeBack;
                    end
                    opImm: begin
                        aluOp     = fieldOp;
                        nextState = writeBack;
                    end
                    opLoad, opStore: nextState = memAccess;
                    opBranch: begin
                        pcWriteCond = 1'b1; // target sits in ALUOut
                        nextState   = fetch;
                    end
                    opJal: begin
                        pcWrite   = 1'b1;
                        regWrite  = 1'b1;
                        wbSel     = wbPc;
                        nextState = fetch;
                    end
                    opJalr: nextState = writeBack;
                    opLui: begin
                        aluOp     = aluPassB;
                        nextState = writeBack;
                    end
                    opAuipc: begin
                        aluASel   = aSelOldPc;
                        nextState = writeBack;
                    end
                    default: nextState = halt; // ECALL and unknown opcodes
                endcase
            end
            memAccess: begin
                addrSel = addrAluOut;
                if (opcode == opStore) begin
                    memWrite  = 1'b1;
                    nextState = fetch;
                end else begin
                    memRead   = 1'b1;
                    nextState = writeBack;
                end
            end
            writeBack: begin
                regWrite = 1'b1;
                if (opcode == opLoad) begin
                    wbSel = wbMdr;
                end else if (opcode == opJalr) begin
                    wbSel   = wbPc;
                    pcWrite = 1'b1;
                end
                nextState = fetch;
            end
            halt:    nextState = halt;
            default: nextState = fetch;
        endcase
    end

    assign halted = (state == halt);

    assert property (@(posedge clk) !(memRead && memWrite));

    // halt is terminal and quiet until reset
    assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted && !(pcWrite || pcWriteCond || irWrite || memWrite || regWrite));

endmodule

`default_nettype wire

//--- regFile.sv
// 32x32 register file, async read, sync write; x0 reads zero whatever is written
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        regWrite,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (regWrite) begin
            regs[rd] <= writeData; // x0 slot written but never read
        end
    end

    assign readData1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign readData2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    assert property (@(posedge clk)
        regWrite && rd == 5'd0 |=> (rs1 != 5'd0) || (readData1 == 32'd0));

endmodule

`default_nettype wire

//--- run.sh
#!/bin/bash
# builds and runs the testbench with Verilator, passes only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tbRvMultiCycle \
    -o simv && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF '** PASS **' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- rvMultiCycleTop.sv
// multicycle RV32I core; load the program through the load port while rstN is low
`timescale 1ns/100ps
`default_nettype none

module rvMultiCycleTop
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   loadEn,
    input  logic [memAddrBits-1:0] loadAddr,
    input  logic [xlen-1:0]        loadData,
    output logic                   storeValid,
    output logic [memAddrBits-1:0] storeAddr,
    output logic [xlen-1:0]        storeData,
    output logic                   halted
);

    logic [xlen-1:0] pc, oldPc, ir, regA, regB, aluOut;
    logic [xlen-1:0] mdr; // memory output register acts as MDR
    logic [xlen-1:0] instr, imm, srcA, srcB, aluResult;
    logic [xlen-1:0] rd1, rd2, wbData, pcNext;
    logic [memAddrBits-1:0] memAddr;
    logic       pcWrite, pcWriteCond, irWrite, memRead, memWrite, regWrite;
    logic       addrSel, branchTaken, fetchCycle;
    logic [1:0] aluASel, aluBSel, wbSel;
    logic [3:0] aluOp;

    // fetched word is still in mdr during decode
    assign instr      = irWrite ? mdr : ir;
    assign fetchCycle = memRead && (addrSel == addrPc);

    always_comb begin
        case (instr[6:0])
            opStore:        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opBranch:       imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                   instr[11:8], 1'b0};
            opLui, opAuipc: imm = {instr[31:12], 12'd0};
            opJal:          imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
            default:        imm = {{20{instr[31]}}, instr[31:20]}; // I format
        endcase
    end

    always_comb begin
        case (aluASel)
            aSelPc:    srcA = pc;
            aSelOldPc: srcA = oldPc;
            default:   srcA = regA;
        endcase
        case (aluBSel)
            bSelRegB: srcB = regB;
            bSelFour: srcB = 32'd4;
            default:  srcB = imm;
        endcase
        case (wbSel)
            wbMdr:   wbData = mdr;
            wbPc:    wbData = pc;
            default: wbData = aluOut;
        endcase
    end

    assign pcNext  = fetchCycle ? aluResult : {aluOut[xlen-1:1], 1'b0}; // JALR clears bit 0
    assign memAddr = (addrSel == addrAluOut) ? aluOut[memAddrBits+1:2] : pc[memAddrBits+1:2];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcWrite || (pcWriteCond && branchTaken)) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchCycle) begin
            oldPc <= pc;
        end
        if (irWrite) begin
            ir <= mdr;
        end
        regA   <= rd1;
        regB   <= rd2;
        aluOut <= aluResult;
    end

    assign storeValid = memWrite;
    assign storeAddr  = memAddr;
    assign storeData  = regB;

    multiCycleControl i_control (
        .clk        (clk),
        .rstN       (rstN),
        .opcode     (ir[6:0]),
        .funct3     (ir[14:12]),
        .funct7b5   (ir[30]),
        .branchTaken(branchTaken),
        .pcWrite    (pcWrite),
        .pcWriteCond(pcWriteCond),
        .irWrite    (irWrite),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .regWrite   (regWrite),
        .addrSel    (addrSel),
        .aluASel    (aluASel),
        .aluBSel    (aluBSel),
        .wbSel      (wbSel),
        .aluOp      (aluOp),
        .halted     (halted)
    );

    aluUnit i_alu (
        .aluOp      (aluOp),
        .srcA       (srcA),
        .srcB       (srcB),
        .cmpA       (regA),
        .cmpB       (regB),
        .funct3     (ir[14:12]),
        .result     (aluResult),
        .branchTaken(branchTaken)
    );

    regFile i_regs (
        .clk      (clk),
        .regWrite (regWrite),
        .rs1      (instr[19:15]),
        .rs2      (instr[24:20]),
        .rd       (instr[11:7]),
        .writeData(wbData),
        .readData1(rd1),
        .readData2(rd2)
    );

    unifiedMemory i_mem (
        .clk      (clk),
        .rstN     (rstN),
        .memRead  (memRead),
        .memWrite (memWrite),
        .addr     (memAddr),
        .writeData(regB),
        .readData (mdr),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData)
    );

endmodule

`default_nettype wire

//--- tbRvMultiCycle.sv
// self-checking testbench; each program is preloaded over the whole memory while rstN is low
`timescale 1ns/100ps
`default_nettype none

module tbRvMultiCycle
    import isaPkg::*;
;

    logic clk, rstN, loadEn;
    logic [memAddrBits-1:0] loadAddr;
    logic [xlen-1:0] loadData;
    logic storeValid, halted;
    logic [memAddrBits-1:0] storeAddr;
    logic [xlen-1:0] storeData;

    logic [31:0] image [memWords];
    logic [31:0] modelMem [memWords];
    logic [memAddrBits-1:0] expAddr [$];
    logic [31:0] expData [$];
    int pcw, storeCount, errCount, failCount;

    rvMultiCycleTop i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] rType(logic [6:0] f7, int rs2, int rs1, int f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opR};
    endfunction
    function automatic logic [31:0] iType(logic [31:0] imm, int rs1, int f3, int rd,
                                          logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction
    function automatic logic [31:0] sType(logic [31:0] imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opStore};
    endfunction
    function automatic logic [31:0] bType(logic [31:0] imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
    endfunction
    function automatic logic [31:0] jType(logic [31:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
    endfunction

    function automatic logic [31:0] fillWord(int addr);
        return 32'h5a5a0000 ^ (addr * 32'h01000193); // any address bit changes the word
    endfunction

    function automatic logic [31:0] aluCalc(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchCond(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // instruction-set model; returns 1 when it reached ECALL or a bad opcode
    function automatic logic runModel();
        logic [31:0] x [32];
        logic [31:0] pc, ins, a, b, res, next, addr;
        logic [31:0] immI, immS, immB, immU, immJ;
        logic wr;
        logic done;
        done = 1'b0;
        pc = 32'd0;
        for (int i = 0; i < 32; i++) x[i] = 32'd0;
        for (int i = 0; i < memWords; i++) modelMem[i] = image[i];
        expAddr.delete();
        expData.delete();
        for (int step = 0; step < 100000 && !done; step++) begin
            ins  = modelMem[pc[11:2]];
            a    = x[ins[19:15]];
            b    = x[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immU = {ins[31:12], 12'd0};
            immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            next = pc + 4;
            wr   = 1'b1;
            res  = 32'd0;
            case (ins[6:0])
                opR:    res = aluCalc(ins[14:12], ins[30], a, b);
                opImm:  res = aluCalc(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, immI);
                opLoad: begin
                    addr = a + immI;
                    res  = modelMem[addr[11:2]];
                end
                opStore: begin
                    wr   = 1'b0;
                    addr = a + immS;
                    modelMem[addr[11:2]] = b;
                    expAddr.push_back(addr[11:2]);
                    expData.push_back(b);
                end
                opBranch: begin
                    wr = 1'b0;
                    if (branchCond(ins[14:12], a, b)) next = pc + immB;
                end
                opJal: begin
                    res  = pc + 4;
                    next = pc + immJ;
                end
                opJalr: begin
                    res  = pc + 4;
                    next = (a + immI) & ~32'd1;
                end
                opLui:   res = immU;
                opAuipc: res = pc + immU;
                default: begin
                    wr   = 1'b0;
                    done = 1'b1;
                end
            endcase
            if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
            pc = next;
        end
        return done;
    endfunction

    task automatic emit(logic [31:0] w);
        image[pcw] = w;
        pcw++;
    endtask

    task automatic loadConst(int rd, logic [31:0] val);
        logic [19:0] upper;
        upper = val[31:12] + val[11]; // addi sign-extends the low part
        emit({upper, rd[4:0], opLui});
        emit(iType(val, rd, 0, rd, opImm));
    endtask

    task automatic clearImage();
        for (int i = 0; i < memWords; i++) image[i] = fillWord(i);
        pcw = 0;
    endtask

    task automatic buildAluProgram();
        int rd, f3;
        logic [31:0] imm;
        clearImage();
        for (int r = 1; r < 32; r++) loadConst(r, $urandom());
        for (int n = 0; n < 40; n++) begin
            rd = 1 + $urandom() % 31;
            f3 = $urandom() % 8;
            if ($urandom() % 2) begin
                emit(rType(((f3 == 0 || f3 == 5) && $urandom() % 2) ? 7'h20 : 7'h00,
                           $urandom() % 32, $urandom() % 32, f3, rd));
            end else begin
                imm = $urandom() % 4096;
                if (f3 == 1) imm = imm & 32'h1f;
                if (f3 == 5) imm = (imm & 32'h1f) | (($urandom() % 2) ? 32'h400 : 32'h0);
                emit(iType(imm, $urandom() % 32, f3, rd, opImm));
            end
        end
        emit(iType(32'h55, 1, 0, 0, opImm)); // both of these target x0
        emit(rType(7'h00, 2, 1, 0, 0));
        for (int r = 0; r < 32; r++) emit(sType(32'h400 + 4 * r, r, 0));
        emit(32'h00000073);
    endtask

    task automatic buildMemProgram();
        clearImage();
        for (int i = 256; i < 260; i++) image[i] = $urandom();
        emit(iType(32'h400, 0, 2, 1, opLoad));
        emit(iType(32'd1, 1, 0, 2, opImm)); // uses the load result at once
        emit(sType(32'h500, 2, 0));
        emit(iType(32'h404, 0, 2, 3, opLoad));
        emit(iType(32'h408, 0, 2, 4, opLoad));
        emit(rType(7'h20, 4, 3, 0, 5));
        emit(sType(32'h504, 5, 0));
        emit(sType(32'h600, 5, 0));
        emit(iType(32'h600, 0, 2, 7, opLoad));
        emit(rType(7'h00, 1, 7, 4, 6));
        emit(sType(32'h508, 6, 0));
        emit(iType(32'h50c, 0, 0, 8, opImm));
        emit(iType(-32'sd256 + 12, 8, 2, 9, opLoad)); // negative offset from a base
        emit(sType(32'h20, 9, 8));
        emit(32'h00000073);
    endtask

    task automatic buildBranchProgram();
        // condition, start, step, bound; operands straddle the sign bit
        logic [31:0] cases [9][4] = '{
            '{0, -1, 1, 0}, '{1, -3, 1, 2}, '{4, -3, 1, 2},
            '{4, 32'h7ffffffd, 1, 32'h80000001}, '{5, 3, -1, -2}, '{6, -3, 1, 2},
            '{6, 32'h7ffffffd, 1, 32'h80000001}, '{7, 32'h80000003, -1, 32'h80000000},
            '{7, 2, -1, 32'hffffffff}};
        clearImage();
        for (int k = 0; k < 9; k++) begin
            emit(iType(0, 0, 0, 10, opImm));
            loadConst(11, cases[k][1]);
            loadConst(12, cases[k][3]);
            emit(iType(1, 10, 0, 10, opImm));
            emit(iType(cases[k][2], 11, 0, 11, opImm));
            emit(bType(-32'sd8, 12, 11, cases[k][0]));
            emit(sType(32'h400 + 8 * k, 10, 0));
            emit(sType(32'h404 + 8 * k, 11, 0));
        end
        emit(32'h00000073);
    endtask

    task automatic buildJumpProgram();
        clearImage();
        emit({20'habcde, 5'd6, opLui});
        emit({20'h12345, 5'd5, opAuipc});
        emit(jType(256 - 4 * pcw, 1)); // call sub at byte 256
        emit(iType(320, 0, 0, 8, opImm));
        emit(iType(1, 8, 0, 9, opJalr)); // odd target, bit 0 dropped
        emit(sType(32'h400, 1, 0));
        emit(sType(32'h404, 5, 0));
        emit(sType(32'h408, 6, 0));
        emit(sType(32'h40c, 9, 0));
        emit(jType(8, 0));
        emit(iType(1, 0, 0, 6, opImm)); // skipped
        emit(sType(32'h410, 6, 0));
        emit(32'h00000073);
        pcw = 64;
        emit({20'h00001, 5'd7, opAuipc});
        emit(sType(32'h414, 7, 0));
        emit(iType(0, 1, 0, 0, opJalr));
        pcw = 80;
        emit(iType(32'h33, 0, 0, 20, opImm));
        emit(sType(32'h418, 20, 0));
        emit(iType(0, 9, 0, 0, opJalr));
    endtask

    task automatic buildBadOpProgram();
        clearImage();
        emit(iType(5, 0, 0, 1, opImm));
        emit(sType(32'h400, 1, 0));
        emit(32'h0000007f); // not an RV32I opcode
        emit(sType(32'h404, 1, 0));
        emit(32'h00000073);
    endtask

    task automatic runProgram(string name);
        int cycles;
        int atHalt;
        logic modelDone;
        modelDone = runModel();
        assert (modelDone) else begin
            failCount++;
            $display("%s: the reference model did not reach a halt", name);
        end
        @(negedge clk);
        rstN = 1'b0;
        for (int i = 0; i < memWords; i++) begin // reset stays low for the whole preload
            loadEn   = 1'b1;
            loadAddr = i[memAddrBits-1:0];
            loadData = image[i];
            @(negedge clk);
        end
        loadEn = 1'b0;
        storeCount = 0;
        rstN = 1'b1;
        cycles = 0;
        while (!halted && cycles < 20000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            failCount++;
            $display("%s: the core never halted within 20000 cycles", name);
        end else begin
            atHalt = storeCount;
            for (int c = 0; c < 50; c++) @(negedge clk);
            assert (storeCount == atHalt && halted) else begin
                failCount++;
                $display("%s: the core stored or left halt after halting", name);
            end
            assert (storeCount == expAddr.size()) else begin
                failCount++;
                $display("%s: %0d stores seen but %0d expected", name, storeCount,
                         expAddr.size());
            end
        end
    endtask

    // store monitor, compared in order against the model
    always @(negedge clk) begin
        if (rstN && storeValid) begin
            assert (storeCount < expAddr.size()) else begin
                failCount++;
                $display("store to %0h at %0t was not expected", storeAddr, $time);
            end
            if (storeCount < expAddr.size()) begin
                assert (storeAddr == expAddr[storeCount] && storeData == expData[storeCount])
                else begin
                    errCount++;
                    $display("ERR %0t: store %0d at %0h data %08h, expected %0h data %08h",
                             $time, storeCount, storeAddr, storeData,
                             expAddr[storeCount], expData[storeCount]);
                end
            end
            storeCount++;
        end
    end

    initial begin
        rstN = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        errCount = 0;
        failCount = 0;
        storeCount = 0;
        void'($urandom(32'h25b2));
        buildAluProgram();
        runProgram("alu");
        buildMemProgram();
        runProgram("load/store");
        buildBranchProgram();
        runProgram("branch");
        buildJumpProgram();
        runProgram("jump");
        buildBadOpProgram();
        runProgram("bad opcode");
        $display("errors: %0d value mismatches, %0d other failures", errCount, failCount);
        if (errCount == 0 && failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- unifiedMemory.sv
// word memory for code and data; read data registered on memRead and held, preload only in reset
`timescale 1ns/100ps
`default_nettype none

module unifiedMemory
    import isaPkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   memRead,
    input  logic                   memWrite,
    input  logic [memAddrBits-1:0] addr,
    input  logic [xlen-1:0]        writeData,
    output logic [xlen-1:0]        readData,
    input  logic                   loadEn,
    input  logic [memAddrBits-1:0] loadAddr,
    input  logic [xlen-1:0]        loadData
);

    logic [xlen-1:0] mem [memWords];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            if (loadEn) begin
                mem[loadAddr] <= loadData;
            end
        end else if (memWrite) begin
            mem[addr] <= writeData;
        end
    end

    // output holds until the next read
    always_ff @(posedge clk) begin
        if (memRead) begin
            readData <= mem[addr];
        end
    end

    assert property (@(posedge clk) !rstN |-> !memWrite);

endmodule

`default_nettype wire
